// ==== rtl/noc_pkg.sv ====
package noc_pkg;

  // Virtual channels carried by one router port.
  localparam int NOC_CHANNELS = 4;

  // Flits are opaque words at this stage of the router.
  localparam int NOC_FLIT_WIDTH = 32;

  // Entries in every flit FIFO, local and internal alike.
  localparam int NOC_DEPTH = 8;

  // Fill level at which a FIFO starts to report almost-full.
  // It leaves room for flits that are already in flight upstream.
  localparam int NOC_THRESHOLD = 6;

  typedef logic [NOC_FLIT_WIDTH-1:0] flit_t;

  // One bit per virtual channel.
  // Used for valid, ready, vc_available and arbiter grants.
  typedef logic [NOC_CHANNELS-1:0] vc_mask_t;

endpackage

// ==== rtl/noc_flit_if.sv ====
`timescale 1ns/1ps

interface noc_flit_if #(
  parameter int FLITS = 1
);
  import noc_pkg::*;

  // Per-channel handshake.
  // On a shared link valid is at most one-hot and flit[0] belongs to the set bit.
  vc_mask_t          valid;
  vc_mask_t          ready;
  vc_mask_t          vc_available;
  flit_t [FLITS-1:0] flit;

  modport initiator (
    output valid,
    input  ready,
    input  vc_available,
    output flit
  );

  modport target (
    input  valid,
    output ready,
    output vc_available,
    input  flit
  );

endinterface

// ==== rtl/noc_fifo.sv ====
`timescale 1ns/1ps

module noc_fifo #(
  parameter int WIDTH     = 32,
  parameter int DEPTH     = 8,
  parameter int THRESHOLD = DEPTH
)(
  input  logic             clk,
  input  logic             i_reset,
  input  logic             i_clear,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_almost_full,
  output logic             o_full
);

  logic [WIDTH-1:0]               mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]       wr_ptr;
  logic [$clog2(DEPTH)-1:0]       rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]     count;
  logic                           push_en;
  logic                           pop_en;

  // Requests that cannot be served are dropped here.
  assign push_en = i_push && !o_full;
  assign pop_en  = i_pop && !o_empty;

  assign o_empty       = (count == '0);
  assign o_almost_full = (count >= THRESHOLD);
  assign o_full        = (count == DEPTH);

  // First word fall through: the head entry is always on the output.
  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

// ==== rtl/noc_flit_if_fifo.sv ====
`timescale 1ns/1ps

module noc_flit_if_fifo #(
  parameter int DEPTH      = noc_pkg::NOC_DEPTH,
  parameter int THRESHOLD  = noc_pkg::NOC_THRESHOLD,
  parameter bit LOCAL_PORT = 1'b1
)(
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_clear,
  output noc_pkg::vc_mask_t        o_empty,
  output noc_pkg::vc_mask_t        o_almost_full,
  output noc_pkg::vc_mask_t        o_full,
  noc_flit_if.target               flit_in_if,
  noc_flit_if.initiator            flit_out_if
);
  import noc_pkg::*;

  if (LOCAL_PORT) begin : g_local_port
    vc_mask_t empty;
    vc_mask_t almost_full;
    vc_mask_t full;

    assign o_empty       = empty;
    assign o_almost_full = almost_full;
    assign o_full        = full;

    // Each channel owns its own FIFO and its own flit lane.
    for (genvar v = 0; v < NOC_CHANNELS; v++) begin : g_channel
      assign flit_in_if.ready[v]        = ~full[v];
      assign flit_in_if.vc_available[v] = ~almost_full[v];
      assign flit_out_if.valid[v]       = ~empty[v];

      noc_fifo #(
        .WIDTH     (NOC_FLIT_WIDTH),
        .DEPTH     (DEPTH),
        .THRESHOLD (THRESHOLD)
      ) u_fifo (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_clear       (i_clear),
        .i_push        (flit_in_if.valid[v]),
        .i_data        (flit_in_if.flit[v]),
        .i_pop         (flit_out_if.ready[v]),
        .o_data        (flit_out_if.flit[v]),
        .o_empty       (empty[v]),
        .o_almost_full (almost_full[v]),
        .o_full        (full[v])
      );
    end
  end else begin : g_internal_port
    logic                                   empty;
    logic                                   almost_full;
    logic                                   full;
    logic                                   push;
    logic                                   pop;
    logic [NOC_CHANNELS+NOC_FLIT_WIDTH-1:0] push_data;
    logic [NOC_CHANNELS+NOC_FLIT_WIDTH-1:0] pop_data;

    assign o_empty       = {NOC_CHANNELS{empty}};
    assign o_almost_full = {NOC_CHANNELS{almost_full}};
    assign o_full        = {NOC_CHANNELS{full}};

    // One shared FIFO, so every channel sees the same flow control.
    assign flit_in_if.ready        = {NOC_CHANNELS{~full}};
    assign flit_in_if.vc_available = {NOC_CHANNELS{~almost_full}};

    // The channel mask travels with the flit through the FIFO.
    assign push      = |flit_in_if.valid;
    assign push_data = {flit_in_if.valid, flit_in_if.flit[0]};
    assign pop       = |(flit_out_if.valid & flit_out_if.ready);

    assign flit_out_if.valid   = empty ? '0 : pop_data[NOC_CHANNELS+NOC_FLIT_WIDTH-1:NOC_FLIT_WIDTH];
    assign flit_out_if.flit[0] = pop_data[NOC_FLIT_WIDTH-1:0];

    noc_fifo #(
      .WIDTH     (NOC_CHANNELS + NOC_FLIT_WIDTH),
      .DEPTH     (DEPTH),
      .THRESHOLD (THRESHOLD)
    ) u_fifo (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_clear       (i_clear),
      .i_push        (push),
      .i_data        (push_data),
      .i_pop         (pop),
      .o_data        (pop_data),
      .o_empty       (empty),
      .o_almost_full (almost_full),
      .o_full        (full)
    );
  end

endmodule

// ==== rtl/noc_vc_arbiter.sv ====
`timescale 1ns/1ps

module noc_vc_arbiter (
  input  logic          clk,
  input  logic          i_reset,
  noc_flit_if.target    local_if,
  noc_flit_if.initiator core_if
);
  import noc_pkg::*;

  vc_mask_t                        eligible;
  vc_mask_t                        grant;
  logic [$clog2(NOC_CHANNELS)-1:0] grant_index;
  logic [$clog2(NOC_CHANNELS)-1:0] pointer;

  // A channel competes only if the shared link can take its flit now.
  assign eligible = local_if.valid & core_if.ready;

  // Search starts at the pointer and wraps around the channels.
  always_comb begin
    int candidate;
    grant       = '0;
    grant_index = pointer;
    candidate   = 0;
    for (int i = 0; i < NOC_CHANNELS; i++) begin
      candidate = (int'(pointer) + i) % NOC_CHANNELS;
      if ((grant == '0) && eligible[candidate]) begin
        grant[candidate] = 1'b1;
        grant_index      = candidate[$clog2(NOC_CHANNELS)-1:0];
      end
    end
  end

  assign core_if.valid   = grant;
  assign core_if.flit[0] = local_if.flit[grant_index];

  // Only the winner is popped from its local buffer.
  assign local_if.ready        = grant;
  assign local_if.vc_available = core_if.vc_available;

  // The channel after the winner gets top priority next time.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      pointer <= '0;
    end else if (|grant) begin
      pointer <= (grant_index == NOC_CHANNELS - 1) ? '0 : grant_index + 1'b1;
    end
  end

endmodule

// ==== rtl/noc_input_stage_top.sv ====
`timescale 1ns/1ps

module noc_input_stage_top (
  input  logic                                             clk,
  input  logic                                             i_reset,
  input  logic                                             i_clear,
  input  noc_pkg::vc_mask_t                                i_valid,
  output noc_pkg::vc_mask_t                                o_ready,
  output noc_pkg::vc_mask_t                                o_vc_available,
  input  noc_pkg::flit_t [noc_pkg::NOC_CHANNELS-1:0]       i_flit,
  output noc_pkg::vc_mask_t                                o_valid,
  input  noc_pkg::vc_mask_t                                i_ready,
  output noc_pkg::flit_t                                   o_flit
);
  import noc_pkg::*;

  noc_flit_if #(.FLITS(NOC_CHANNELS)) in_link ();
  noc_flit_if #(.FLITS(NOC_CHANNELS)) local_link ();
  noc_flit_if #(.FLITS(1))            core_link ();
  noc_flit_if #(.FLITS(1))            out_link ();

  // Local port side, one lane per channel.
  assign in_link.valid  = i_valid;
  assign in_link.flit   = i_flit;
  assign o_ready        = in_link.ready;
  assign o_vc_available = in_link.vc_available;

  // Downstream side of the shared buffer.
  assign o_valid        = out_link.valid;
  assign o_flit         = out_link.flit[0];
  assign out_link.ready = i_ready;

  // Downstream has no separate availability signal, so ready stands in for it.
  assign out_link.vc_available = i_ready;

  noc_flit_if_fifo #(
    .DEPTH      (NOC_DEPTH),
    .THRESHOLD  (NOC_THRESHOLD),
    .LOCAL_PORT (1'b1)
  ) u_local_fifo (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_clear       (i_clear),
    .o_empty       (),
    .o_almost_full (),
    .o_full        (),
    .flit_in_if    (in_link.target),
    .flit_out_if   (local_link.initiator)
  );

  noc_vc_arbiter u_vc_arbiter (
    .clk      (clk),
    .i_reset  (i_reset),
    .local_if (local_link.target),
    .core_if  (core_link.initiator)
  );

  noc_flit_if_fifo #(
    .DEPTH      (NOC_DEPTH),
    .THRESHOLD  (NOC_THRESHOLD),
    .LOCAL_PORT (1'b0)
  ) u_core_fifo (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_clear       (i_clear),
    .o_empty       (),
    .o_almost_full (),
    .o_full        (),
    .flit_in_if    (core_link.target),
    .flit_out_if   (out_link.initiator)
  );

endmodule

// ==== verif/noc_tb_clock.sv ====
`timescale 1ns/1ps

module noc_tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
)(
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset is held for a fixed number of rising edges, then released on an edge.
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

// ==== verif/noc_tb.sv ====
`timescale 1ns/1ps

module noc_tb;
  import noc_pkg::*;

  localparam int SINGLE_CYCLES       = 4;
  localparam int ROUND_ROBIN_CYCLES  = 8;
  localparam int RANDOM_CYCLES       = 300;
  localparam int BACKPRESSURE_CYCLES = 40;
  localparam int CLEAR_FILL_CYCLES   = 14;
  localparam int DRAIN_CYCLES        = 60;
  localparam int OUTPUT_WAIT_CYCLES  = 10;
  localparam int TEST_CYCLES         = 8 + SINGLE_CYCLES + ROUND_ROBIN_CYCLES + RANDOM_CYCLES +
                                       BACKPRESSURE_CYCLES + CLEAR_FILL_CYCLES + 3 * DRAIN_CYCLES;
  localparam int WATCHDOG_CYCLES     = TEST_CYCLES * 4 + 200;

  logic                     clk;
  logic                     reset;
  logic                     i_clear;
  vc_mask_t                 i_valid;
  vc_mask_t                 o_ready;
  vc_mask_t                 o_vc_available;
  flit_t [NOC_CHANNELS-1:0] i_flit;
  vc_mask_t                 o_valid;
  vc_mask_t                 i_ready;
  flit_t                    o_flit;

  integer seed = 32'h8729_1f31;
  string  cur_test = "reset";

  // Expected flits in arrival order, each tagged with its channel.
  flit_t exp_flit [$];
  int    exp_vc [$];

  noc_tb_clock u_clock (
    .o_clk   (clk),
    .o_reset (reset)
  );

  noc_input_stage_top UUT (
    .clk            (clk),
    .i_reset        (reset),
    .i_clear        (i_clear),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .o_vc_available (o_vc_available),
    .i_flit         (i_flit),
    .o_valid        (o_valid),
    .i_ready        (i_ready),
    .o_flit         (o_flit)
  );

  task automatic report_failure(input string message);
    $display("%s", message);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_flit(input string test, input flit_t expected, input flit_t actual);
    if (expected !== actual) begin
      report_failure($sformatf("Error in %s: expected %h, actual %h", test, expected, actual));
    end
  endtask

  task automatic compare_mask(input string test, input vc_mask_t expected, input vc_mask_t actual);
    if (expected !== actual) begin
      report_failure($sformatf("Error in %s: expected %b, actual %b", test, expected, actual));
    end
  endtask

  // Outputs are matched against the oldest expected flit of the same channel.
  task automatic track_transfers();
    int ch;
    int idx;
    ch  = 0;
    idx = -1;
    if (reset || i_clear) begin
      exp_flit.delete();
      exp_vc.delete();
    end else begin
      if ((o_valid & i_ready) != '0) begin
        if ((o_valid & (o_valid - 1'b1)) != '0) begin
          report_failure($sformatf("Output valid %b is not one-hot in %s", o_valid, cur_test));
        end
        for (int v = 0; v < NOC_CHANNELS; v++) begin
          if (o_valid[v]) ch = v;
        end
        for (int i = exp_vc.size() - 1; i >= 0; i--) begin
          if (exp_vc[i] == ch) idx = i;
        end
        if (idx < 0) begin
          report_failure($sformatf("Unexpected flit on channel %0d in %s", ch, cur_test));
        end else begin
          compare_flit(cur_test, exp_flit[idx], o_flit);
          exp_flit.delete(idx);
          exp_vc.delete(idx);
        end
      end
      for (int v = 0; v < NOC_CHANNELS; v++) begin
        if (i_valid[v] && o_ready[v]) begin
          exp_flit.push_back(i_flit[v]);
          exp_vc.push_back(v);
        end
      end
    end
  endtask

  always @(posedge clk) track_transfers();

  task automatic wait_output(input vc_mask_t mask, input flit_t data);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > OUTPUT_WAIT_CYCLES) begin
        report_failure($sformatf("No output flit appeared in time in %s", cur_test));
      end
    end while ((o_valid & i_ready) == '0);
    compare_mask(cur_test, mask, o_valid);
    compare_flit(cur_test, data, o_flit);
  endtask

  // Sampled on the falling edge, after the monitor has updated the queues.
  task automatic wait_drained(input int max_cycles);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_flit.size() != 0) begin
      if (waited == max_cycles) begin
        report_failure($sformatf("Buffered flits did not drain in %s", cur_test));
      end
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
  endtask

  task automatic test_reset_state();
    cur_test = "test_reset_state";
    compare_mask(cur_test, '0, o_valid);
    compare_mask(cur_test, '1, o_ready);
    compare_mask(cur_test, '1, o_vc_available);
  endtask

  task automatic test_round_robin();
    flit_t data [NOC_CHANNELS];
    cur_test = "test_round_robin";
    i_ready <= '1;
    i_valid <= '1;
    for (int v = 0; v < NOC_CHANNELS; v++) begin
      data[v] = $random(seed);
      i_flit[v] <= data[v];
    end
    @(posedge clk);
    i_valid <= '0;
    for (int v = 0; v < NOC_CHANNELS; v++) begin
      wait_output(vc_mask_t'(1 << v), data[v]);
    end
  endtask

  task automatic test_single_flit();
    flit_t data;
    cur_test = "test_single_flit";
    data = $random(seed);
    i_ready   <= '1;
    i_valid   <= 4'b0100;
    i_flit[2] <= data;
    // The flit is accepted at this edge.
    @(posedge clk);
    compare_mask(cur_test, 4'b0100, o_ready & 4'b0100);
    i_valid <= '0;
    @(posedge clk);
    compare_mask(cur_test, '0, o_valid);
    @(posedge clk);
    compare_mask(cur_test, 4'b0100, o_valid);
    compare_flit(cur_test, data, o_flit);
  endtask

  task automatic test_random_traffic();
    cur_test = "test_random_traffic";
    repeat (RANDOM_CYCLES) begin
      i_valid <= vc_mask_t'($random(seed));
      i_ready <= vc_mask_t'($random(seed));
      for (int v = 0; v < NOC_CHANNELS; v++) begin
        i_flit[v] <= $random(seed);
      end
      @(posedge clk);
    end
    i_valid <= '0;
    i_ready <= '1;
    wait_drained(DRAIN_CYCLES);
  endtask

  task automatic test_backpressure();
    int waited;
    cur_test = "test_backpressure";
    waited = 0;
    i_ready   <= '0;
    i_valid   <= 4'b0010;
    i_flit[1] <= $random(seed);
    do begin
      @(posedge clk);
      if (!o_ready[1] && o_vc_available[1]) begin
        report_failure("Channel 1 stayed available after its ready fell");
      end
      if (waited == BACKPRESSURE_CYCLES) begin
        report_failure("Channel 1 ready never fell while the output was stalled");
      end
      i_flit[1] <= $random(seed);
      waited++;
    end while (o_ready[1]);
    i_valid <= '0;
    i_ready <= '1;
    wait_drained(DRAIN_CYCLES);
  endtask

  task automatic test_clear();
    flit_t data;
    cur_test = "test_clear";
    i_ready <= '0;
    i_valid <= 4'b1001;
    repeat (CLEAR_FILL_CYCLES) begin
      i_flit[0] <= $random(seed);
      i_flit[3] <= $random(seed);
      @(posedge clk);
    end
    i_valid <= '0;
    i_clear <= 1'b1;
    @(posedge clk);
    i_clear <= 1'b0;
    @(posedge clk);
    compare_mask(cur_test, '0, o_valid);
    compare_mask(cur_test, '1, o_ready);
    compare_mask(cur_test, '1, o_vc_available);
    data = $random(seed);
    i_ready   <= '1;
    i_valid   <= 4'b0001;
    i_flit[0] <= data;
    @(posedge clk);
    i_valid <= '0;
    wait_output(4'b0001, data);
    wait_drained(DRAIN_CYCLES);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("Watchdog expired before the tests finished");
  end

  initial begin
    i_clear = 1'b0;
    i_valid = '0;
    i_ready = '1;
    i_flit  = '0;
    do begin
      @(posedge clk);
    end while (reset);
    test_reset_state();
    test_round_robin();
    test_single_flit();
    test_random_traffic();
    test_backpressure();
    test_clear();
    if (exp_flit.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure("Some accepted flits never came out");
    end
  end

endmodule

// ==== list.f ====
rtl/noc_pkg.sv
rtl/noc_flit_if.sv
rtl/noc_fifo.sv
rtl/noc_flit_if_fifo.sv
rtl/noc_vc_arbiter.sv
rtl/noc_input_stage_top.sv
verif/noc_tb_clock.sv
verif/noc_tb.sv
